// File: src/hl2_config.svh
`ifndef HL2_CONFIG_SVH
`define HL2_CONFIG_SVH

// command bus field widths
`define HL2_ADDR_W 6
`define HL2_DATA_W 32

// receivers in this build
`define HL2_NR 4

// queue depths
`define HL2_CMD_FIFO_DEPTH  8
`define HL2_RESP_FIFO_DEPTH 4

// command address map
`define HL2_ADDR_GENERAL  6'h00
`define HL2_ADDR_TX_FREQ  6'h01
// receiver k sits at rx_freq0 + k
`define HL2_ADDR_RX_FREQ0 6'h02
`define HL2_ADDR_TX_DRIVE 6'h09

`endif

// File: src/cmd_pkg.sv
`include "hl2_config.svh"

package cmd_pkg;

  // where a command came from
  typedef enum logic {
    HOST = 1'b0,
    LINK = 1'b1
  } cmd_src_e;

  // one command as queued by either source
  typedef struct packed {
    logic [`HL2_ADDR_W-1:0] addr;
    logic [`HL2_DATA_W-1:0] data;
    logic                   resp_rqst;
  } cmd_t;

  // command after arbitration, tagged with its source
  typedef struct packed {
    cmd_t     cmd;
    cmd_src_e src;
  } bus_cmd_t;

  // 40 bit response word read by the upstream packetizer
  typedef struct packed {
    logic [`HL2_ADDR_W-1:0] addr;
    cmd_src_e               src;
    logic                   mox;
    logic [`HL2_DATA_W-1:0] data;
  } resp_t;

endpackage

// File: src/radio_pkg.sv
`include "hl2_config.svh"

package radio_pkg;

  // decoded radio settings held by the register bank
  typedef struct packed {
    logic                                    mox;
    // receiver count minus one
    logic [3:0]                              nrx;
    logic [`HL2_DATA_W-1:0]                  tx_freq;
    logic [`HL2_NR-1:0][`HL2_DATA_W-1:0]     rx_freq;
    logic [7:0]                              tx_drive;
  } radio_state_t;

endpackage

// File: src/sync_fifo.sv
module sync_fifo #(
  parameter int  DEPTH     = 8,
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk_ctrl,
  input  logic     rst_i,
  input  logic     push_i,
  input  payload_t din_i,
  input  logic     pop_i,
  output payload_t dout_o,
  output logic     empty_o,
  output logic     full_o,
  output logic     overflow_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             overflow_q;
  logic             do_push;
  logic             do_pop;

  // a pop frees a slot for a push in the same cycle
  assign do_pop  = pop_i && !empty_o;
  assign do_push = push_i && (!full_o || do_pop);

  always_ff @(posedge clk_ctrl) begin
    if (do_push) begin
      mem[wr_ptr_q] <= din_i;
    end
  end

  always_ff @(posedge clk_ctrl) begin
    if (rst_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_q <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
      // sticky until reset
      if (push_i && !do_push) begin
        overflow_q <= 1'b1;
      end
    end
  end

  // head is always visible
  assign dout_o     = mem[rd_ptr_q];
  assign empty_o    = (count_q == '0);
  assign full_o     = (count_q == FULL_CNT);
  assign overflow_o = overflow_q;

  a_overflow_sticky: assert property (@(posedge clk_ctrl) disable iff (rst_i)
    overflow_q |=> overflow_q);

endmodule

// File: src/cmd_arbiter.sv
module cmd_arbiter (
  input  logic              clk_ctrl,
  input  logic              rst_i,
  input  cmd_pkg::cmd_t     host_head_i,
  input  cmd_pkg::cmd_t     link_head_i,
  input  logic              host_empty_i,
  input  logic              link_empty_i,
  input  logic              resp_full_i,
  output logic              host_pop_o,
  output logic              link_pop_o,
  output cmd_pkg::bus_cmd_t bus_cmd_o,
  output logic              bus_valid_o
);
  import cmd_pkg::*;

  cmd_src_e last_grant_q;
  bus_cmd_t bus_cmd_q;
  logic     bus_valid_q;
  logic     host_req;
  logic     link_req;
  logic     grant_host;
  logic     grant_link;

  ////////////////////////////////////////////////////////////////////////////
  // grant

  // full response queue holds off both sources
  assign host_req = !host_empty_i && !resp_full_i;
  assign link_req = !link_empty_i && !resp_full_i;

  // host wins unless it was served last and the link is waiting
  assign grant_host = host_req && (!link_req || last_grant_q == LINK);
  assign grant_link = link_req && !grant_host;

  always_ff @(posedge clk_ctrl) begin
    if (rst_i) begin
      // host first after reset
      last_grant_q <= LINK;
      bus_valid_q  <= 1'b0;
    end else begin
      bus_valid_q <= grant_host || grant_link;
      if (grant_host) begin
        last_grant_q <= HOST;
      end else if (grant_link) begin
        last_grant_q <= LINK;
      end
    end
  end

  // bus payload
  always_ff @(posedge clk_ctrl) begin
    if (grant_host) begin
      bus_cmd_q <= '{cmd: host_head_i, src: HOST};
    end else if (grant_link) begin
      bus_cmd_q <= '{cmd: link_head_i, src: LINK};
    end
  end

  assign host_pop_o  = grant_host;
  assign link_pop_o  = grant_link;
  assign bus_cmd_o   = bus_cmd_q;
  assign bus_valid_o = bus_valid_q;

  ////////////////////////////////////////////////////////////////////////////
  // checks

  a_one_pop: assert property (@(posedge clk_ctrl) disable iff (rst_i)
    !(host_pop_o && link_pop_o));

  a_pop_not_empty: assert property (@(posedge clk_ctrl) disable iff (rst_i)
    (host_pop_o |-> !host_empty_i) and (link_pop_o |-> !link_empty_i));

endmodule

// File: src/radio_regs.sv
`include "hl2_config.svh"

module radio_regs (
  input  logic                    clk_ctrl,
  input  logic                    rst_i,
  input  cmd_pkg::bus_cmd_t       bus_cmd_i,
  input  logic                    bus_valid_i,
  input  logic                    tx_inhibit_i,
  output logic [`HL2_DATA_W-1:0]  readback_o,
  output radio_pkg::radio_state_t radio_o,
  output logic                    tx_on_o
);
  import radio_pkg::*;

  localparam logic [3:0] NRX_MAX = 4'(`HL2_NR - 1);
  localparam logic [`HL2_ADDR_W-1:0] RX_COUNT = `HL2_ADDR_W'(`HL2_NR);
  localparam int RX_IDX_W = $clog2(`HL2_NR);

  radio_state_t           radio_q;
  logic                   tx_on_q;
  logic [`HL2_ADDR_W-1:0] addr;
  logic [`HL2_DATA_W-1:0] data;
  logic [`HL2_ADDR_W-1:0] rx_idx;
  logic [RX_IDX_W-1:0]    rx_sel;
  logic                   rx_hit;
  logic [3:0]             nrx_clamped;

  assign addr = bus_cmd_i.cmd.addr;
  assign data = bus_cmd_i.cmd.data;

  // receiver slot decode, slots past the last receiver are dead
  assign rx_idx = addr - `HL2_ADDR_RX_FREQ0;
  assign rx_sel = rx_idx[RX_IDX_W-1:0];
  assign rx_hit = (addr >= `HL2_ADDR_RX_FREQ0) && (rx_idx < RX_COUNT);

  // clamp requested receiver count
  assign nrx_clamped = (data[6:3] > NRX_MAX) ? NRX_MAX : data[6:3];

  ////////////////////////////////////////////////////////////////////////////
  // settings

  always_ff @(posedge clk_ctrl) begin
    if (rst_i) begin
      radio_q <= '0;
      tx_on_q <= 1'b0;
    end else begin
      // external inhibit overrides mox
      tx_on_q <= radio_q.mox && !tx_inhibit_i;
      if (bus_valid_i) begin
        if (addr == `HL2_ADDR_GENERAL) begin
          radio_q.mox <= data[0];
          radio_q.nrx <= nrx_clamped;
        end else if (addr == `HL2_ADDR_TX_FREQ) begin
          radio_q.tx_freq <= data;
        end else if (addr == `HL2_ADDR_TX_DRIVE) begin
          radio_q.tx_drive <= data[31:24];
        end else if (rx_hit) begin
          radio_q.rx_freq[rx_sel] <= data;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // readback, same bit positions as the write

  always_comb begin
    readback_o = '0;
    if (addr == `HL2_ADDR_GENERAL) begin
      readback_o[6:3] = radio_q.nrx;
      readback_o[0]   = radio_q.mox;
    end else if (addr == `HL2_ADDR_TX_FREQ) begin
      readback_o = radio_q.tx_freq;
    end else if (addr == `HL2_ADDR_TX_DRIVE) begin
      readback_o[31:24] = radio_q.tx_drive;
    end else if (rx_hit) begin
      readback_o = radio_q.rx_freq[rx_sel];
    end
  end

  assign radio_o = radio_q;
  assign tx_on_o = tx_on_q;

  a_nrx_range: assert property (@(posedge clk_ctrl) disable iff (rst_i)
    radio_q.nrx <= NRX_MAX);

endmodule

// File: src/resp_gen.sv
`include "hl2_config.svh"

module resp_gen (
  input  logic                   clk_ctrl,
  input  logic                   rst_i,
  input  cmd_pkg::bus_cmd_t      bus_cmd_i,
  input  logic                   bus_valid_i,
  input  logic [`HL2_DATA_W-1:0] readback_i,
  input  logic                   mox_i,
  output cmd_pkg::resp_t         resp_o,
  output logic                   resp_push_o
);
  import cmd_pkg::*;

  resp_t resp_q;
  logic  push_q;
  logic  want_resp;

  assign want_resp = bus_valid_i && bus_cmd_i.cmd.resp_rqst;

  always_ff @(posedge clk_ctrl) begin
    if (rst_i) begin
      push_q <= 1'b0;
    end else begin
      push_q <= want_resp;
    end
  end

  // mox_i is still the value from before this write lands
  always_ff @(posedge clk_ctrl) begin
    if (want_resp) begin
      resp_q <= '{addr: bus_cmd_i.cmd.addr, src: bus_cmd_i.src, mox: mox_i,
                  data: readback_i};
    end
  end

  assign resp_o      = resp_q;
  assign resp_push_o = push_q;

endmodule

// File: src/hl2_ctrl_core.sv
`include "hl2_config.svh"

module hl2_ctrl_core (
  input  logic                    clk_ctrl,
  input  logic                    rst_i,
  input  cmd_pkg::cmd_t           host_cmd_i,
  input  cmd_pkg::cmd_t           link_cmd_i,
  input  logic                    host_valid_i,
  input  logic                    link_valid_i,
  input  logic                    tx_inhibit_i,
  input  logic                    resp_rd_i,
  output radio_pkg::radio_state_t radio_o,
  output logic                    tx_on_o,
  output cmd_pkg::resp_t          resp_o,
  output logic                    resp_avail_o,
  output logic                    cmd_overflow_o
);
  import cmd_pkg::*;

  cmd_t                   host_head;
  cmd_t                   link_head;
  logic                   host_empty;
  logic                   link_empty;
  logic                   host_pop;
  logic                   link_pop;
  logic                   host_ovf;
  logic                   link_ovf;
  bus_cmd_t               bus_cmd;
  logic                   bus_valid;
  logic [`HL2_DATA_W-1:0] readback;
  resp_t                  resp_new;
  logic                   resp_push;
  logic                   resp_empty;
  logic                   resp_full;

  ////////////////////////////////////////////////////////////////////////////
  // command queues, one per source

  sync_fifo #(.DEPTH(`HL2_CMD_FIFO_DEPTH), .payload_t(cmd_t)) host_fifo (
    .clk_ctrl  (clk_ctrl),
    .rst_i     (rst_i),
    .push_i    (host_valid_i),
    .din_i     (host_cmd_i),
    .pop_i     (host_pop),
    .dout_o    (host_head),
    .empty_o   (host_empty),
    .full_o    (),
    .overflow_o(host_ovf)
  );

  sync_fifo #(.DEPTH(`HL2_CMD_FIFO_DEPTH), .payload_t(cmd_t)) link_fifo (
    .clk_ctrl  (clk_ctrl),
    .rst_i     (rst_i),
    .push_i    (link_valid_i),
    .din_i     (link_cmd_i),
    .pop_i     (link_pop),
    .dout_o    (link_head),
    .empty_o   (link_empty),
    .full_o    (),
    .overflow_o(link_ovf)
  );

  assign cmd_overflow_o = host_ovf | link_ovf;

  cmd_arbiter arbiter (
    .clk_ctrl    (clk_ctrl),
    .rst_i       (rst_i),
    .host_head_i (host_head),
    .link_head_i (link_head),
    .host_empty_i(host_empty),
    .link_empty_i(link_empty),
    .resp_full_i (resp_full),
    .host_pop_o  (host_pop),
    .link_pop_o  (link_pop),
    .bus_cmd_o   (bus_cmd),
    .bus_valid_o (bus_valid)
  );

  radio_regs regs (
    .clk_ctrl    (clk_ctrl),
    .rst_i       (rst_i),
    .bus_cmd_i   (bus_cmd),
    .bus_valid_i (bus_valid),
    .tx_inhibit_i(tx_inhibit_i),
    .readback_o  (readback),
    .radio_o     (radio_o),
    .tx_on_o     (tx_on_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // response path to the packetizer

  resp_gen resp_builder (
    .clk_ctrl   (clk_ctrl),
    .rst_i      (rst_i),
    .bus_cmd_i  (bus_cmd),
    .bus_valid_i(bus_valid),
    .readback_i (readback),
    .mox_i      (radio_o.mox),
    .resp_o     (resp_new),
    .resp_push_o(resp_push)
  );

  sync_fifo #(.DEPTH(`HL2_RESP_FIFO_DEPTH), .payload_t(resp_t)) resp_fifo (
    .clk_ctrl  (clk_ctrl),
    .rst_i     (rst_i),
    .push_i    (resp_push),
    .din_i     (resp_new),
    .pop_i     (resp_rd_i),
    .dout_o    (resp_o),
    .empty_o   (resp_empty),
    .full_o    (resp_full),
    .overflow_o()
  );

  assign resp_avail_o = !resp_empty;

endmodule

// File: verification/tb_hl2_ctrl_core.sv
`include "hl2_config.svh"

module tb_hl2_ctrl_core;
  import cmd_pkg::*;
  import radio_pkg::*;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 10;
  localparam int BURST_LEN    = `HL2_CMD_FIFO_DEPTH + `HL2_RESP_FIFO_DEPTH + 8;
  // 29 directed commands, then the fill and the burst
  localparam int N_CMDS       = 29 + (`HL2_CMD_FIFO_DEPTH - 1) + BURST_LEN;
  localparam int CMD_MARGIN   = 25;
  localparam int RX_W         = $clog2(`HL2_NR);
  localparam logic [3:0] NRX_MAX = 4'(`HL2_NR - 1);

  logic         clk_ctrl;
  logic         rst_i;
  cmd_t         host_cmd_i;
  cmd_t         link_cmd_i;
  logic         host_valid_i;
  logic         link_valid_i;
  logic         tx_inhibit_i;
  logic         resp_rd_i;
  radio_state_t radio_o;
  logic         tx_on_o;
  resp_t        resp_o;
  logic         resp_avail_o;
  logic         cmd_overflow_o;

  radio_state_t model_q;
  resp_t        exp_q[$];
  resp_t        exp_resp;
  integer       seed;

  hl2_ctrl_core UUT (
    .clk_ctrl      (clk_ctrl),
    .rst_i         (rst_i),
    .host_cmd_i    (host_cmd_i),
    .link_cmd_i    (link_cmd_i),
    .host_valid_i  (host_valid_i),
    .link_valid_i  (link_valid_i),
    .tx_inhibit_i  (tx_inhibit_i),
    .resp_rd_i     (resp_rd_i),
    .radio_o       (radio_o),
    .tx_on_o       (tx_on_o),
    .resp_o        (resp_o),
    .resp_avail_o  (resp_avail_o),
    .cmd_overflow_o(cmd_overflow_o)
  );

  initial begin
    clk_ctrl = 1'b0;
    forever #(CLK_PERIOD / 2) clk_ctrl = ~clk_ctrl;
  end

  ////////////////////////////////////////////////////////////////////////////
  // reporting and compares

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check_resp(input string name, input resp_t got, input resp_t exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED: %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_radio(input string name, input radio_state_t got,
                             input radio_state_t exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED: %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED: %s got %h expected %h", name, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model of the register bank and responses

  function automatic logic [`HL2_DATA_W-1:0] model_readback(
      input radio_state_t st, input logic [`HL2_ADDR_W-1:0] addr);
    logic [`HL2_DATA_W-1:0] rb;
    logic [`HL2_ADDR_W-1:0] idx;
    rb  = '0;
    idx = addr - `HL2_ADDR_RX_FREQ0;
    if (addr == `HL2_ADDR_GENERAL) begin
      rb[6:3] = st.nrx;
      rb[0]   = st.mox;
    end else if (addr == `HL2_ADDR_TX_FREQ) begin
      rb = st.tx_freq;
    end else if (addr == `HL2_ADDR_TX_DRIVE) begin
      rb[31:24] = st.tx_drive;
    end else if (addr >= `HL2_ADDR_RX_FREQ0 && idx < `HL2_ADDR_W'(`HL2_NR)) begin
      rb = st.rx_freq[idx[RX_W-1:0]];
    end
    return rb;
  endfunction

  function automatic radio_state_t model_write(input radio_state_t st, input cmd_t c);
    radio_state_t           nx;
    logic [`HL2_ADDR_W-1:0] idx;
    nx  = st;
    idx = c.addr - `HL2_ADDR_RX_FREQ0;
    if (c.addr == `HL2_ADDR_GENERAL) begin
      nx.mox = c.data[0];
      nx.nrx = (c.data[6:3] > NRX_MAX) ? NRX_MAX : c.data[6:3];
    end else if (c.addr == `HL2_ADDR_TX_FREQ) begin
      nx.tx_freq = c.data;
    end else if (c.addr == `HL2_ADDR_TX_DRIVE) begin
      nx.tx_drive = c.data[31:24];
    end else if (c.addr >= `HL2_ADDR_RX_FREQ0 && idx < `HL2_ADDR_W'(`HL2_NR)) begin
      nx.rx_freq[idx[RX_W-1:0]] = c.data;
    end
    return nx;
  endfunction

  // response carries the state from before its own write
  function automatic resp_t expected_resp(input radio_state_t st, input cmd_t c,
                                          input cmd_src_e src);
    resp_t r;
    r.addr = c.addr;
    r.src  = src;
    r.mox  = st.mox;
    r.data = model_readback(st, c.addr);
    return r;
  endfunction

  task automatic model_cmd(input cmd_t c, input cmd_src_e src);
    if (c.resp_rqst) begin
      exp_q.push_back(expected_resp(model_q, c, src));
    end
    model_q = model_write(model_q, c);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers, all entered on a falling edge

  function automatic cmd_t make_cmd(input logic [`HL2_ADDR_W-1:0] addr,
                                    input logic [`HL2_DATA_W-1:0] data);
    cmd_t c;
    c.addr      = addr;
    c.data      = data;
    c.resp_rqst = 1'b1;
    return c;
  endfunction

  // host goes into the model first, matching the arbiter right after reset
  task automatic send_cmds(input logic host_en, input cmd_t host_cmd,
                           input logic link_en, input cmd_t link_cmd);
    host_cmd_i   = host_cmd;
    host_valid_i = host_en;
    link_cmd_i   = link_cmd;
    link_valid_i = link_en;
    if (host_en) begin
      model_cmd(host_cmd, HOST);
    end
    if (link_en) begin
      model_cmd(link_cmd, LINK);
    end
    @(negedge clk_ctrl);
    host_valid_i = 1'b0;
    link_valid_i = 1'b0;
  endtask

  // watchdog bounds the wait
  task automatic read_resp();
    while (!resp_avail_o) begin
      @(negedge clk_ctrl);
    end
    resp_rd_i = 1'b1;
    @(negedge clk_ctrl);
    resp_rd_i = 1'b0;
  endtask

  task automatic write_and_check(input logic [`HL2_ADDR_W-1:0] addr,
                                 input logic [`HL2_DATA_W-1:0] data);
    send_cmds(1'b1, make_cmd(addr, data), 1'b0, '0);
    read_resp();
    check_radio("radio_o", radio_o, model_q);
  endtask

  // every popped response against the model, sampled before the edge updates
  always @(posedge clk_ctrl) begin
    if (!rst_i && resp_rd_i && resp_avail_o) begin
      if (exp_q.size() == 0) begin
        fail_run("a response was popped while the model expected none");
      end else begin
        exp_resp = exp_q.pop_front();
        check_resp("resp_o", resp_o, exp_resp);
      end
    end
  end

  initial begin
    #((RESET_CYCLES + N_CMDS * CMD_MARGIN) * CLK_PERIOD);
    fail_run("timeout: the run did not finish within its cycle budget");
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence

  initial begin
    seed         = 32'he4ec;
    rst_i        = 1'b1;
    host_cmd_i   = '0;
    link_cmd_i   = '0;
    host_valid_i = 1'b0;
    link_valid_i = 1'b0;
    tx_inhibit_i = 1'b0;
    resp_rd_i    = 1'b0;
    model_q      = '0;
    repeat (RESET_CYCLES) @(negedge clk_ctrl);
    rst_i = 1'b0;
    @(negedge clk_ctrl);

    // reset values
    check_radio("radio_o", radio_o, '0);
    check_flag("tx_on_o", tx_on_o, 1'b0);
    check_flag("resp_avail_o", resp_avail_o, 1'b0);
    check_flag("cmd_overflow_o", cmd_overflow_o, 1'b0);

    // both sources in one cycle, host priority is still fresh from reset
    send_cmds(1'b1, make_cmd(`HL2_ADDR_TX_FREQ, $random(seed)),
              1'b1, make_cmd(`HL2_ADDR_TX_FREQ, $random(seed)));
    read_resp();
    read_resp();
    check_radio("radio_o", radio_o, model_q);

    // every mapped address, then one hole in the map
    // second sweep reads back what the first one wrote
    repeat (2) begin
      write_and_check(`HL2_ADDR_GENERAL, $random(seed));
      write_and_check(`HL2_ADDR_TX_FREQ, $random(seed));
      for (int k = 0; k < `HL2_NR; k++) begin
        write_and_check(`HL2_ADDR_RX_FREQ0 + `HL2_ADDR_W'(k), $random(seed));
      end
      write_and_check(`HL2_ADDR_TX_DRIVE, $random(seed));
      write_and_check(6'h2a, $random(seed));
    end

    // nrx field of all ones, written twice so the readback shows the clamp
    write_and_check(`HL2_ADDR_GENERAL, 32'h0000_0078);
    write_and_check(`HL2_ADDR_GENERAL, 32'h0000_0078);
    for (int k = `HL2_NR; k < int'(`HL2_ADDR_TX_DRIVE - `HL2_ADDR_RX_FREQ0); k++) begin
      write_and_check(`HL2_ADDR_RX_FREQ0 + `HL2_ADDR_W'(k), $random(seed));
      write_and_check(`HL2_ADDR_RX_FREQ0 + `HL2_ADDR_W'(k), $random(seed));
    end

    // mox against the inhibit input
    write_and_check(`HL2_ADDR_GENERAL, 32'h0000_0001);
    repeat (2) @(negedge clk_ctrl);
    check_flag("tx_on_o", tx_on_o, model_q.mox & ~tx_inhibit_i);
    tx_inhibit_i = 1'b1;
    repeat (2) @(negedge clk_ctrl);
    check_flag("tx_on_o", tx_on_o, model_q.mox & ~tx_inhibit_i);
    write_and_check(`HL2_ADDR_GENERAL, 32'h0000_0000);
    repeat (2) @(negedge clk_ctrl);
    check_flag("tx_on_o", tx_on_o, model_q.mox & ~tx_inhibit_i);
    write_and_check(`HL2_ADDR_GENERAL, 32'h0000_0000);
    tx_inhibit_i = 1'b0;

    if (exp_q.size() != 0) begin
      fail_run("responses were expected but never came back");
    end

    // back-pressure with no reads
    for (int k = 0; k < `HL2_CMD_FIFO_DEPTH - 1; k++) begin
      send_cmds(1'b1, make_cmd(`HL2_ADDR_W'($random(seed) & 15), $random(seed)),
                1'b0, '0);
    end
    repeat (8) @(negedge clk_ctrl);
    check_flag("cmd_overflow_o", cmd_overflow_o, 1'b0);
    for (int k = 0; k < BURST_LEN; k++) begin
      send_cmds(1'b1, make_cmd(`HL2_ADDR_W'($random(seed) & 15), $random(seed)),
                1'b0, '0);
      check_flag("resp_avail_o", resp_avail_o, 1'b1);
    end
    @(negedge clk_ctrl);
    check_flag("cmd_overflow_o", cmd_overflow_o, 1'b1);
    check_flag("resp_avail_o", resp_avail_o, 1'b1);
    for (int k = 0; k < `HL2_RESP_FIFO_DEPTH; k++) begin
      read_resp();
    end
    repeat (2) @(negedge clk_ctrl);

    $display("TB PASSED");
    $finish;
  end

endmodule

// File: files.f
+incdir+src
src/cmd_pkg.sv
src/radio_pkg.sv
src/sync_fifo.sv
src/cmd_arbiter.sv
src/radio_regs.sv
src/resp_gen.sv
src/hl2_ctrl_core.sv
verification/tb_hl2_ctrl_core.sv

// File: Makefile
# Verilator simulation of the control core testbench

VERILATOR ?= verilator
TOP       ?= tb_hl2_ctrl_core
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# a failing run ends in $fatal, so the binary's exit status fails make
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
